//--- verification/video_vectors.txt
# cmd addr data count step name, with addr data step in hex and count in decimal
# Writes use data plus k times step at addr plus k, reads expect the same sequence
WP 00 21 64 35 pal_fill
RP 00 21 4 35 pal_readback
WG 00 00 128 00 map_clear
RG 7e 00 4 00 map_clear_readback
FRAME 00 00 1 00 backdrop
WG 00 01 64 03 map_l0_pattern
WG 40 02 64 07 map_l1_pattern
RG 00 01 5 03 map_l0_readback
RG 40 02 2 07 map_l1_readback
FRAME 00 00 1 00 priority
WG 80 0d 4 0e scroll_set
RG 80 0d 4 0e scroll_readback
FRAME 00 00 1 00 scroll_wrap
WP 00 c3 64 5b pal_refill
RP 3c 17 4 5b pal_refill_readback
FRAME 00 00 1 00 scroll_new_palette
WG 80 00 4 00 scroll_clear
RG 80 00 4 00 scroll_clear_readback
FRAME 00 00 1 00 raster_final

//--- tb.f
verilog/video_pkg.sv
verilog/video_cen.sv
verilog/video_timer.sv
verilog/video_cpu_dec.sv
verilog/tile_layer.sv
verilog/video_colmix.sv
verilog/video_top.sv
verification/video_checker.sv
verification/tb_video.sv

//--- Bender.yml
package:
  name: video_subsystem

sources:
  - files:
      - verilog/video_pkg.sv
      - verilog/video_cen.sv
      - verilog/video_timer.sv
      - verilog/video_cpu_dec.sv
      - verilog/tile_layer.sv
      - verilog/video_colmix.sv
      - verilog/video_top.sv
  - target: simulation
    files:
      - verification/video_checker.sv
      - verification/tb_video.sv

//--- verification/tb_video.sv
// Testbench top for the video subsystem
// Clock and reset, vector file reader, CPU bus driver
// Watchdog and per-test summary
`timescale 1ns/1ps

module tb_video import video_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;

    logic      clk;
    logic      rst_n;
    logic      gfx_cs;
    logic      pal_cs;
    cpu_bus_t  cpu;
    logic      pxl2_cen;
    logic      pxl_cen;
    logic      lhbl;
    logic      lvbl;
    logic      lhbl_dly;
    logic      lvbl_dly;
    logic      hs;
    logic      vs;
    logic      cpu_irqn;
    cpu_data_t gfx_dout;
    cpu_data_t pal_dout;
    rgb_t      rgb;

    // Parsed vector file, one entry per command line
    string vec_cmd [$];
    string vec_name [$];
    int    vec_addr [$];
    int    vec_data [$];
    int    vec_count [$];
    int    vec_step [$];
    int    n_pass;
    int    n_fail;
    logic  vec_ready;

    video_top u_dut (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .gfx_cs   ( gfx_cs   ),
        .pal_cs   ( pal_cs   ),
        .cpu      ( cpu      ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  ),
        .LHBL     ( lhbl     ),
        .LVBL     ( lvbl     ),
        .LHBL_dly ( lhbl_dly ),
        .LVBL_dly ( lvbl_dly ),
        .HS       ( hs       ),
        .VS       ( vs       ),
        .cpu_irqn ( cpu_irqn ),
        .gfx_dout ( gfx_dout ),
        .pal_dout ( pal_dout ),
        .rgb      ( rgb      )
    );

    video_checker u_chk (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .gfx_cs   ( gfx_cs   ),
        .pal_cs   ( pal_cs   ),
        .cpu      ( cpu      ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly ),
        .hs       ( hs       ),
        .vs       ( vs       ),
        .cpu_irqn ( cpu_irqn ),
        .rgb      ( rgb      )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_vectors(output bit ok);
        int    fd;
        int    ch;
        int    a;
        int    d;
        int    c;
        int    s;
        string cmd;
        string name;
        ok = 1'b0;
        fd = $fopen("verification/video_vectors.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd[0] == "#") begin
                    // Skip the rest of a comment line
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else if ($fscanf(fd, "%h %h %d %h %s", a, d, c, s, name) == 5) begin
                    vec_cmd.push_back(cmd);
                    vec_addr.push_back(a);
                    vec_data.push_back(d);
                    vec_count.push_back(c);
                    vec_step.push_back(s);
                    vec_name.push_back(name);
                end else begin
                    $display("Malformed vector line starting with %s", cmd);
                    ok = 1'b0;
                end
            end
            $fclose(fd);
            if (vec_cmd.size() == 0) begin
                ok = 1'b0;
            end
        end
    endtask

    // One access, cs held for a single clk
    task automatic bus_cycle(input bit to_pal, input int addr, input int data, input bit write);
        // Random idle gap before the access
        repeat ($urandom % 4) @(negedge clk);
        @(negedge clk);
        gfx_cs   = !to_pal;
        pal_cs   = to_pal;
        cpu.addr = cpu_addr_t'(addr);
        cpu.data = cpu_data_t'(data);
        cpu.we   = write;
        @(negedge clk);
        gfx_cs = 1'b0;
        pal_cs = 1'b0;
        cpu.we = 1'b0;
    endtask

    task automatic run_vector(input int i, output int errs);
        bit        to_pal;
        cpu_data_t expected;
        cpu_data_t actual;
        errs   = 0;
        to_pal = (vec_cmd[i] == "WP") || (vec_cmd[i] == "RP");
        if (vec_cmd[i] == "WG" || vec_cmd[i] == "WP") begin
            for (int k = 0; k < vec_count[i]; k++) begin
                bus_cycle(to_pal, vec_addr[i] + k, vec_data[i] + k * vec_step[i], 1'b1);
            end
        end else if (vec_cmd[i] == "RG" || vec_cmd[i] == "RP") begin
            for (int k = 0; k < vec_count[i]; k++) begin
                bus_cycle(to_pal, vec_addr[i] + k, 0, 1'b0);
                // Registered read data, one clk after cs
                expected = cpu_data_t'(vec_data[i] + k * vec_step[i]);
                actual   = to_pal ? pal_dout : gfx_dout;
                if (actual !== expected) begin
                    $display("ERROR %s addr %02h expected %02h actual %02h",
                             vec_name[i], cpu_addr_t'(vec_addr[i] + k), expected, actual);
                    errs++;
                end
            end
        end else if (vec_cmd[i] == "FRAME") begin
            // From one mixer frame start to the next
            @(posedge lvbl_dly);
            @(negedge clk);
            u_chk.begin_frame(vec_name[i]);
            @(posedge lvbl_dly);
            @(negedge clk);
            u_chk.end_frame(errs);
        end else begin
            $display("Unknown command %s in test %s", vec_cmd[i], vec_name[i]);
            errs = 1;
        end
    endtask

    task automatic check_reset(output int errs);
        errs  = 0;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            // Sample after a clk edge has applied the reset
            @(posedge clk);
            @(negedge clk);
            if (rgb !== '0 || hs !== 1'b0 || vs !== 1'b0 || lhbl_dly !== 1'b0 ||
                lvbl_dly !== 1'b0 || cpu_irqn !== 1'b1) begin
                $write("ERROR reset expected rgb=0000 hs=0 vs=0 dly=00 irqn=1");
                $display(" actual rgb=%04h hs=%b vs=%b dly=%b%b irqn=%b",
                         rgb, hs, vs, lhbl_dly, lvbl_dly, cpu_irqn);
                errs++;
            end
        end
        rst_n = 1'b1;
    endtask

    task automatic print_result(input string name, input int errs);
        if (errs == 0) begin
            $display("PASS %s", name);
            n_pass++;
        end else begin
            $display("FAIL %s with %0d errors", name, errs);
            n_fail++;
        end
    endtask

    initial begin
        bit ok;
        int errs;
        rst_n     = 1'b0;
        gfx_cs    = 1'b0;
        pal_cs    = 1'b0;
        cpu       = '0;
        n_pass    = 0;
        n_fail    = 0;
        vec_ready = 1'b0;
        void'($urandom(62501));
        load_vectors(ok);
        vec_ready = 1'b1;
        check_reset(errs);
        print_result("reset", errs);
        if (ok) begin
            for (int i = 0; i < vec_cmd.size(); i++) begin
                run_vector(i, errs);
                print_result(vec_name[i], errs);
            end
        end else begin
            $display("Vector file missing, empty or malformed");
            n_fail++;
        end
        $display("Tests done: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Two frame times per vector, one extra slot for the reset test
    initial begin
        wait (vec_ready);
        #(longint'(vec_cmd.size() + 1) * H_TOTAL * V_TOTAL * 4 * CLK_PERIOD * 2);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- verification/video_checker.sv
// Frame checker for the video subsystem
// Shadows CPU writes to the tile maps, scroll registers and palette
// Models every output pixel and the raster shape of a checked frame
`timescale 1ns/1ps

module video_checker import video_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     gfx_cs,
    input logic     pal_cs,
    input cpu_bus_t cpu,
    input logic     pxl2_cen,
    input logic     pxl_cen,
    input logic     lhbl,
    input logic     lvbl,
    input logic     lhbl_dly,
    input logic     lvbl_dly,
    input logic     hs,
    input logic     vs,
    input logic     cpu_irqn,
    input rgb_t     rgb
);

    // Shadow state from snooped writes
    colour_t   map_sh [NUM_LAYERS][MAP_DIM*MAP_DIM];
    scroll_t   hscr_sh [NUM_LAYERS];
    scroll_t   vscr_sh [NUM_LAYERS];
    cpu_data_t pal_sh [PAL_ENTRIES*2];

    // Output raster position
    int    x = 0;
    int    y = 0;
    logic  lhbl_q = 1'b0;
    logic  lvbl_q = 1'b0;
    logic  lvbl_raw_q = 1'b1;
    logic  pxl2_q = 1'b0;

    logic  frame_on = 1'b0;
    string frame_name = "";
    int    frame_errs = 0;
    int    vis_cnt = 0;
    int    hs_cnt = 0;
    int    vs_cnt = 0;
    int    irq_cnt = 0;
    int    lhbl_cnt = 0;
    int    lvbl_cnt = 0;
    int    pix_cnt = 0;
    int    clk_cnt = 0;
    int    pxl2_cnt = 0;

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int l = 0; l < NUM_LAYERS; l++) begin
                hscr_sh[l] <= '0;
                vscr_sh[l] <= '0;
            end
        end else if (gfx_cs && cpu.we) begin
            if (!cpu.addr[7]) begin
                map_sh[cpu.addr[6]][cpu.addr[5:0]] <= cpu.data[3:0];
            end else if (cpu.addr[0]) begin
                vscr_sh[cpu.addr[1]] <= cpu.data[5:0];
            end else begin
                hscr_sh[cpu.addr[1]] <= cpu.data[5:0];
            end
        end
        if (pal_cs && cpu.we) begin
            pal_sh[cpu.addr[5:0]] <= cpu.data;
        end
    end

    function automatic rgb_t model_pixel(int px, int py);
        int        entry;
        int        col;
        int        row;
        colour_t   c;
        cpu_data_t lo;
        cpu_data_t hi;
        rgb_t      res;
        entry = 0;
        // First opaque layer from layer 0 upward, 16 entries per layer
        for (int l = 0; l < NUM_LAYERS; l++) begin
            col = ((px + hscr_sh[l]) % (MAP_DIM << TILE_BITS)) >> TILE_BITS;
            row = ((py + vscr_sh[l]) % (MAP_DIM << TILE_BITS)) >> TILE_BITS;
            c   = map_sh[l][row * MAP_DIM + col];
            if (entry == 0 && c != 0) begin
                entry = l * 16 + c;
            end
        end
        lo        = pal_sh[entry * 2];
        hi        = pal_sh[entry * 2 + 1];
        res.red   = lo[4:0];
        res.green = {hi[1:0], lo[7:5]};
        res.blue  = hi[6:2];
        return res;
    endfunction

    function automatic void check_count(string what, int actual, int expected);
        if (actual != expected) begin
            frame_errs++;
            $display("ERROR %s %s expected %0d actual %0d", frame_name, what, expected, actual);
        end
    endfunction

    task automatic begin_frame(input string name);
        frame_name = name;
        frame_errs = 0;
        vis_cnt    = 0;
        hs_cnt     = 0;
        vs_cnt     = 0;
        irq_cnt    = 0;
        lhbl_cnt   = 0;
        lvbl_cnt   = 0;
        pix_cnt    = 0;
        clk_cnt    = 0;
        pxl2_cnt   = 0;
        frame_on   = 1'b1;
    endtask

    task automatic end_frame(output int errs);
        frame_on = 1'b0;
        check_count("visible pixels", vis_cnt, H_ACTIVE * V_ACTIVE);
        check_count("HS strobes", hs_cnt, (HS_END - HS_START) * V_TOTAL);
        check_count("VS strobes", vs_cnt, (VS_END - VS_START) * H_TOTAL);
        check_count("irq strobes", irq_cnt, IRQ_LINES * H_TOTAL);
        check_count("LHBL strobes", lhbl_cnt, H_ACTIVE * V_TOTAL);
        check_count("LVBL strobes", lvbl_cnt, V_ACTIVE * H_TOTAL);
        check_count("pxl_cen strobes", pix_cnt, H_TOTAL * V_TOTAL);
        check_count("clocks per frame", clk_cnt, H_TOTAL * V_TOTAL * 4);
        check_count("pxl2_cen strobes", pxl2_cnt, H_TOTAL * V_TOTAL * 2);
        errs = frame_errs;
    endtask

    // Double rate strobe toggles every clk
    always @(posedge clk) begin
        if (frame_on) begin
            clk_cnt  = clk_cnt + 1;
            pxl2_cnt = pxl2_cnt + (pxl2_cen ? 1 : 0);
            if (pxl2_cen === pxl2_q) begin
                frame_errs++;
                if (frame_errs <= 4) begin
                    $display("ERROR %s pxl2_cen expected %b actual %b",
                             frame_name, !pxl2_q, pxl2_cen);
                end
            end
        end
        pxl2_q = pxl2_cen;
    end

    // One sample per pixel, registered outputs seen before the edge
    always @(posedge clk) begin
        rgb_t exp_rgb;
        if (pxl_cen) begin
            if (lhbl_dly && !lhbl_q) begin
                x = 0;
                y = (lvbl_dly && !lvbl_q) ? 0 : y + 1;
            end else begin
                x = x + 1;
            end
            if (frame_on) begin
                exp_rgb = (lhbl_dly && lvbl_dly) ? model_pixel(x, y) : rgb_t'(0);
                if (rgb !== exp_rgb) begin
                    frame_errs++;
                    // First few mismatches only
                    if (frame_errs <= 4) begin
                        $display("ERROR %s pixel (%0d,%0d) expected %04h actual %04h",
                                 frame_name, x, y, exp_rgb, rgb);
                    end
                end
                vis_cnt  = vis_cnt + ((lhbl_dly && lvbl_dly) ? 1 : 0);
                hs_cnt   = hs_cnt + (hs ? 1 : 0);
                vs_cnt   = vs_cnt + (vs ? 1 : 0);
                irq_cnt  = irq_cnt + (!cpu_irqn ? 1 : 0);
                lhbl_cnt = lhbl_cnt + (lhbl ? 1 : 0);
                lvbl_cnt = lvbl_cnt + (lvbl ? 1 : 0);
                pix_cnt  = pix_cnt + 1;
                // Interrupt starts with vblank
                if (lvbl_raw_q && !lvbl && cpu_irqn !== 1'b0) begin
                    frame_errs++;
                    $display("ERROR %s cpu_irqn at LVBL fall expected 0 actual %b",
                             frame_name, cpu_irqn);
                end
            end
            lhbl_q     = lhbl_dly;
            lvbl_q     = lvbl_dly;
            lvbl_raw_q = lvbl;
        end
    end

endmodule

//--- verilog/video_top.sv
// Video subsystem top level
// Clock enables, raster timer, CPU decoder, tile layers, colour mixer
`timescale 1ns/1ps

module video_top import video_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      gfx_cs,
    input  logic      pal_cs,
    input  cpu_bus_t  cpu,
    output logic      pxl2_cen,
    output logic      pxl_cen,
    output logic      LHBL,
    output logic      LVBL,
    output logic      LHBL_dly,
    output logic      LVBL_dly,
    output logic      HS,
    output logic      VS,
    output logic      cpu_irqn,
    output cpu_data_t gfx_dout,
    output cpu_data_t pal_dout,
    output rgb_t      rgb
);

    screen_pos_t           scr;
    layer_pxl_t            layer_pxl;
    cpu_data_t             layer_rd [NUM_LAYERS];
    logic [NUM_LAYERS-1:0] layer_we;
    logic [NUM_LAYERS-1:0] layer_sel;
    logic                  pal_we;

    // Undelayed blanks straight from the timer
    assign LHBL = scr.lhbl;
    assign LVBL = scr.lvbl;

    video_cen u_cen (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    video_timer u_timer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .scr      ( scr      ),
        .HS       ( HS       ),
        .VS       ( VS       ),
        .cpu_irqn ( cpu_irqn )
    );

    video_cpu_dec u_dec (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .gfx_cs    ( gfx_cs    ),
        .pal_cs    ( pal_cs    ),
        .cpu       ( cpu       ),
        .layer_rd  ( layer_rd  ),
        .layer_we  ( layer_we  ),
        .layer_sel ( layer_sel ),
        .pal_we    ( pal_we    ),
        .gfx_dout  ( gfx_dout  )
    );

    // One layer per index, layer 0 on top
    for (genvar g = 0; g < NUM_LAYERS; g++) begin : g_layer
        tile_layer u_layer (
            .clk     ( clk           ),
            .rst_n   ( rst_n         ),
            .pxl_cen ( pxl_cen       ),
            .scr     ( scr           ),
            .cpu     ( cpu           ),
            .we      ( layer_we[g]   ),
            .sel     ( layer_sel[g]  ),
            .pxl     ( layer_pxl[g]  ),
            .rd      ( layer_rd[g]   )
        );
    end

    video_colmix u_colmix (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .scr       ( scr       ),
        .layer_pxl ( layer_pxl ),
        .cpu       ( cpu       ),
        .pal_we    ( pal_we    ),
        .pal_cs    ( pal_cs    ),
        .rgb       ( rgb       ),
        .LHBL_dly  ( LHBL_dly  ),
        .LVBL_dly  ( LVBL_dly  ),
        .pal_dout  ( pal_dout  )
    );

endmodule

//--- verilog/video_colmix.sv
// Colour mixer
// Layer priority, byte-written palette RAM, RGB555 decode
// Blank delay and palette read-back
`timescale 1ns/1ps

module video_colmix import video_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  screen_pos_t scr,
    input  layer_pxl_t  layer_pxl,
    input  cpu_bus_t    cpu,
    input  logic        pal_we,
    input  logic        pal_cs,
    output rgb_t        rgb,
    output logic        LHBL_dly,
    output logic        LVBL_dly,
    output cpu_data_t   pal_dout
);

    // Low byte {g[2:0], r}, high byte {0, b, g[4:3]}
    cpu_data_t pal_lo [PAL_ENTRIES];
    cpu_data_t pal_hi [PAL_ENTRIES];
    pal_idx_t  cpu_idx;
    pal_idx_t  pxl_idx;
    rgb_t      pxl_rgb;
    logic      lhbl_d1;
    logic      lvbl_d1;

    assign cpu_idx = pal_idx_t'(cpu.addr >> 1);

    always_ff @(posedge clk) begin
        if (pal_we) begin
            if (cpu.addr[PAL_HI_BIT]) begin
                pal_hi[cpu_idx] <= cpu.data;
            end else begin
                pal_lo[cpu_idx] <= cpu.data;
            end
        end
    end

    // Lowest non-transparent layer wins, backdrop is entry 0
    always_comb begin
        pxl_idx = '0;
        for (int i = NUM_LAYERS - 1; i >= 0; i--) begin
            if (layer_pxl[i] != '0) begin
                pxl_idx = {layer_idx_t'(i), layer_pxl[i]};
            end
        end
    end

    assign pxl_rgb.red   = pal_lo[pxl_idx][4:0];
    assign pxl_rgb.green = {pal_hi[pxl_idx][1:0], pal_lo[pxl_idx][7:5]};
    assign pxl_rgb.blue  = pal_hi[pxl_idx][6:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lhbl_d1  <= 1'b0;
            lvbl_d1  <= 1'b0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
            rgb      <= '0;
        end else if (pxl_cen) begin
            // Two strobes, matching the layer plus mixer stages
            lhbl_d1  <= scr.lhbl;
            lvbl_d1  <= scr.lvbl;
            LHBL_dly <= lhbl_d1;
            LVBL_dly <= lvbl_d1;
            // Blanked with the same delay as the pixel
            rgb      <= (lhbl_d1 && lvbl_d1) ? pxl_rgb : '0;
        end
    end

    // Palette read, held until the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pal_dout <= '0;
        end else if (pal_cs && !cpu.we) begin
            pal_dout <= cpu.addr[PAL_HI_BIT] ? pal_hi[cpu_idx] : pal_lo[cpu_idx];
        end
    end

endmodule

//--- verilog/tile_layer.sv
// Scroll tile layer
// 8x8 tile map of solid colours, horizontal and vertical scroll
// Registered pixel lookup and CPU read byte
`timescale 1ns/1ps

module tile_layer import video_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  screen_pos_t scr,
    input  cpu_bus_t    cpu,
    input  logic        we,
    input  logic        sel,
    output colour_t     pxl,
    output cpu_data_t   rd
);

    colour_t   map_mem [MAP_DIM*MAP_DIM];
    scroll_t   hscroll;
    scroll_t   vscroll;
    hcnt_t     hpos;
    vcnt_t     vpos;
    map_idx_t  pxl_idx;
    cpu_data_t rd_byte;

    // Map writes, no reset on the RAM
    always_ff @(posedge clk) begin
        if (we && !cpu.addr[GFX_SCR_BIT]) begin
            map_mem[map_idx_t'(cpu.addr)] <= cpu.data[3:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hscroll <= '0;
            vscroll <= '0;
        end else if (we && cpu.addr[GFX_SCR_BIT]) begin
            if (cpu.addr[GFX_SCR_V_BIT]) begin
                vscroll <= scroll_t'(cpu.data);
            end else begin
                hscroll <= scroll_t'(cpu.data);
            end
        end
    end

    // Scrolled position wraps at 64 pixels
    assign hpos    = scr.hdump + hscroll;
    assign vpos    = scr.vdump + vscroll;
    // Row times 8 plus column
    assign pxl_idx = {vpos[$bits(vcnt_t)-1:TILE_BITS], hpos[$bits(hcnt_t)-1:TILE_BITS]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl <= '0;
        end else if (pxl_cen) begin
            pxl <= map_mem[pxl_idx];
        end
    end

    // CPU read byte, zero when this layer is not addressed
    always_comb begin
        if (!cpu.addr[GFX_SCR_BIT]) begin
            rd_byte = cpu_data_t'(map_mem[map_idx_t'(cpu.addr)]);
        end else if (cpu.addr[GFX_SCR_V_BIT]) begin
            rd_byte = cpu_data_t'(vscroll);
        end else begin
            rd_byte = cpu_data_t'(hscroll);
        end
    end

    assign rd = sel ? rd_byte : '0;

endmodule

//--- verilog/video_cpu_dec.sv
// CPU bus decoder
// Per-layer write strobes and read selects, palette write strobe
// Registered gfx read-back mux
`timescale 1ns/1ps

module video_cpu_dec import video_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  gfx_cs,
    input  logic                  pal_cs,
    input  cpu_bus_t              cpu,
    input  cpu_data_t             layer_rd [NUM_LAYERS],
    output logic [NUM_LAYERS-1:0] layer_we,
    output logic [NUM_LAYERS-1:0] layer_sel,
    output logic                  pal_we,
    output cpu_data_t             gfx_dout
);

    layer_idx_t lyr;

    // Scroll space takes the layer from a low bit, map space from a high one
    assign lyr = cpu.addr[GFX_SCR_BIT] ? layer_idx_t'(cpu.addr[GFX_SCR_LYR_BIT])
                                       : layer_idx_t'(cpu.addr[GFX_MAP_LYR_BIT]);

    for (genvar g = 0; g < NUM_LAYERS; g++) begin : g_strobe
        assign layer_sel[g] = gfx_cs && (lyr == layer_idx_t'(g));
        assign layer_we[g]  = layer_sel[g] && cpu.we;
    end

    assign pal_we = pal_cs && cpu.we;

    // Read data held until the next gfx read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gfx_dout <= '0;
        end else if (gfx_cs && !cpu.we) begin
            gfx_dout <= layer_rd[lyr];
        end
    end

endmodule

//--- verilog/video_timer.sv
// Raster timer
// Pixel and line counters, blanking levels, syncs
// CPU interrupt at the start of vertical blank
`timescale 1ns/1ps

module video_timer import video_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    output screen_pos_t scr,
    output logic        HS,
    output logic        VS,
    output logic        cpu_irqn
);

    hcnt_t hcnt;
    vcnt_t vcnt;
    logic  h_last;
    logic  v_last;

    // End of line and end of frame
    assign h_last = hcnt == hcnt_t'(H_TOTAL - 1);
    assign v_last = vcnt == vcnt_t'(V_TOTAL - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (h_last) begin
                hcnt <= '0;
                // Line advances once per wrap
                vcnt <= v_last ? '0 : vcnt + vcnt_t'(1);
            end else begin
                hcnt <= hcnt + hcnt_t'(1);
            end
        end
    end

    // Screen position for the layers and mixer
    assign scr.hdump = hcnt;
    assign scr.vdump = vcnt;
    // Blank levels high inside the visible area
    assign scr.lhbl  = hcnt < H_ACTIVE;
    assign scr.lvbl  = vcnt < V_ACTIVE;

    // Sync windows from the package
    assign HS = (hcnt >= HS_START) && (hcnt < HS_END);
    assign VS = (vcnt >= VS_START) && (vcnt < VS_END);

    // Low for the first lines of vblank, lines all through
    assign cpu_irqn = !((vcnt >= V_ACTIVE) && (vcnt < V_ACTIVE + IRQ_LINES));

endmodule

//--- verilog/video_cen.sv
// Pixel clock enables
// pxl2_cen one clk in 2, pxl_cen one clk in 4
`timescale 1ns/1ps

module video_cen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    // Free-running divider
    logic [1:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 2'd1;
            // Odd counts give the double rate strobe
            pxl2_cen <= cnt[0];
            // Only count 3 gives the pixel strobe
            pxl_cen  <= &cnt;
        end
    end

endmodule

//--- verilog/video_pkg.sv
// Shared definitions for the video subsystem
// Raster timing windows, layer and map sizes, CPU address map bits
// Width typedefs and packed structs for buses and screen position
package video_pkg;

    // Horizontal raster, in pixel clocks
    localparam int H_TOTAL   = 64;
    localparam int H_ACTIVE  = 48;
    localparam int HS_START  = 52;
    localparam int HS_END    = 56;
    // Vertical raster, in lines
    localparam int V_TOTAL   = 40;
    localparam int V_ACTIVE  = 32;
    localparam int VS_START  = 34;
    localparam int VS_END    = 36;
    // Interrupt held low for this many lines once vblank starts
    localparam int IRQ_LINES = 2;

    // Layers and tile maps
    localparam int NUM_LAYERS  = 2;
    localparam int TILE_BITS   = 3;
    localparam int MAP_DIM     = 8;
    localparam int PAL_ENTRIES = 32;

    // gfx_cs address bits
    localparam int GFX_SCR_BIT     = 7;
    localparam int GFX_MAP_LYR_BIT = 6;
    localparam int GFX_SCR_LYR_BIT = 1;
    localparam int GFX_SCR_V_BIT   = 0;
    // pal_cs address bit for the high byte
    localparam int PAL_HI_BIT      = 0;

    typedef logic [5:0] hcnt_t;
    typedef logic [5:0] vcnt_t;
    typedef logic [5:0] scroll_t;
    typedef logic [5:0] map_idx_t;
    // Zero is transparent
    typedef logic [3:0] colour_t;
    typedef logic [$clog2(NUM_LAYERS)-1:0] layer_idx_t;
    typedef logic [$clog2(PAL_ENTRIES)-1:0] pal_idx_t;
    typedef logic [7:0] cpu_addr_t;
    typedef logic [7:0] cpu_data_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

    typedef struct packed {
        hcnt_t hdump;
        vcnt_t vdump;
        logic  lhbl;
        logic  lvbl;
    } screen_pos_t;

    typedef struct packed {
        cpu_addr_t addr;
        cpu_data_t data;
        logic      we;
    } cpu_bus_t;

    typedef colour_t [NUM_LAYERS-1:0] layer_pxl_t;

endpackage
